//--- alu16.f
+incdir+design
design/alu_pkg.sv
design/claAdder.sv
design/paddsbUnit.sv
design/reductionUnit.sv
design/barrelShifter.sv
design/aluUnit.sv
design/flagRegister.sv
design/aluTop.sv
testbench/alu_checker.sv
testbench/aluTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := aluTb
FILELIST  := alu16.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/aluTb.sv
module aluTb import alu_pkg::*; ();

  localparam int OPS         = 200;               // Operations per test
  localparam int CYCLE_LIMIT = 6 * OPS * 3 + 100; // Watchdog bound

  logic     clk, rstN, issue, done;
  aluReqS   req;
  aluRespS  resp;
  aluFlagsS flags;

  aluReqS      pendQ[$];     // Issued, waiting for done
  aluReqS      curReq;
  aluRespS     curExp;
  aluFlagsS    modelFlags;   // Reference flag state
  logic        flagPending;  // Flag compare due at the next falling edge
  logic [31:0] rngState, rnd;
  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleCount = 0;

  aluTop dut0 (.clk, .rstN, .issue, .req, .done, .resp, .flags);

  bind aluTop aluChecker checker0 (
    .clk(clk), .rstN(rstN), .issue(issue), .done(done), .resp(resp), .flags(flags)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, operations stopped completing", cycleCount);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus and reference helpers
  ////////////////////////////////////////
  function automatic logic [31:0] randWord();
    rngState = rngState ^ (rngState << 13);  // xorshift32
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic aluRespS expectedResp(input aluReqS r);
    aluRespS e;
    int      wide, lane;
    e    = '0;
    e.op = r.op;
    case (r.op)
      ADD, SUB: begin
        wide = (r.op == ADD) ? int'($signed(r.a)) + int'($signed(r.b))
                             : int'($signed(r.a)) - int'($signed(r.b));
        e.neg    = wide[15];                        // Sign of the wrapped sum
        e.ovfl   = (wide > 32767) || (wide < -32768);
        e.result = (wide > 32767) ? 16'h7FFF : (wide < -32768) ? 16'h8000 : wide[15:0];
      end
      XOR: e.result = r.a ^ r.b;
      RED: begin
        wide = int'($signed(r.a[15:8])) + int'($signed(r.a[7:0]))
             + int'($signed(r.b[15:8])) + int'($signed(r.b[7:0]));
        e.result = wide[15:0];
      end
      SLL: e.result = r.a << r.b[3:0];
      SRA: e.result = $signed(r.a) >>> r.b[3:0];
      ROR: for (int i = 0; i < 16; i++) e.result[i] = r.a[(i + int'(r.b[3:0])) % 16];
      PADDSB: for (lane = 0; lane < 4; lane++) begin
        wide = int'($signed(r.a[4*lane +: 4])) + int'($signed(r.b[4*lane +: 4]));
        wide = (wide > 7) ? 7 : (wide < -8) ? -8 : wide;  // Lane clamp
        e.result[4*lane +: 4] = wide[3:0];
      end
      LW, SW: e.result = (r.a & 16'hFFFE) + (r.b << 1);  // Wraps at 16 bits
      default: e.error = 1'b1;
    endcase
    return e;
  endfunction

  function automatic aluFlagsS nextFlags(input aluFlagsS f, input aluRespS e);
    aluFlagsS upd;
    upd = f;
    if (e.op == ADD || e.op == SUB) begin
      upd.z = (e.result == 16'h0);
      upd.v = e.ovfl;
      upd.n = e.neg;
    end else if (e.op == XOR || e.op == SLL || e.op == SRA || e.op == ROR) begin
      upd.z = (e.result == 16'h0);                  // Z only
    end
    return upd;
  endfunction

  task automatic checkEq(input string what, input logic [15:0] got, input logic [15:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic issueOp(input logic [3:0] op, input dataT a, input dataT b);
    aluReqS r;
    r = '{op: aluOpE'(op), a: a, b: b};
    @(negedge clk);
    issue = 1'b1;
    req   = r;
    pendQ.push_back(r);
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (flagPending) begin
      checkEq("flags", {13'h0, flags}, {13'h0, modelFlags});
      flagPending = 1'b0;
    end
    if (done && pendQ.size() == 0) begin
      errorCount++;
      $display("Error at %0t: done pulsed with no operation outstanding", $time);
    end else if (done) begin
      curReq = pendQ.pop_front();
      curExp = expectedResp(curReq);
      checkEq($sformatf("op %h result", curReq.op), resp.result, curExp.result);
      checkEq($sformatf("op %h error", curReq.op), {15'h0, resp.error}, {15'h0, curExp.error});
      checkEq($sformatf("op %h ovfl", curReq.op), {15'h0, resp.ovfl}, {15'h0, curExp.ovfl});
      checkEq($sformatf("op %h neg", curReq.op), {15'h0, resp.neg}, {15'h0, curExp.neg});
      checkEq($sformatf("op %h echo", curReq.op), {12'h0, resp.op}, {12'h0, curExp.op});
      modelFlags  = nextFlags(modelFlags, curExp);
      flagPending = 1'b1;                           // Flags land one edge later
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    string      names [6];
    logic [3:0] op;
    dataT       opA, opB;
    int         errMark;
    names       = '{"ADD/SUB", "XOR/shifts", "PADDSB/RED", "LW/SW", "illegal", "mixed"};
    rngState    = 32'h8f81_c4ca;
    rstN        = 1'b0;
    issue       = 1'b0;
    req         = '0;
    modelFlags  = '0;
    flagPending = 1'b0;
    repeat (4) @(negedge clk);
    rstN = 1'b1;
    for (int t = 0; t < 6; t++) begin
      errMark = errorCount;
      for (int i = 0; i < OPS; i++) begin
        rnd = randWord();
        opA = rnd[15:0];
        opB = rnd[31:16];
        case (t)
          0: begin
            op = (i % 2 == 0) ? ADD : SUB;
            if (i % 8 == 0) {opA, opB} = {16'h7FFF, 16'h0001};  // Positive overflow
            if (i % 8 == 2) {opA, opB} = {16'h8000, 16'hFFFF};  // Negative overflow
            if (i % 8 == 1) {opA, opB} = {16'h8000, 16'h0001};
            if (i % 8 == 3) {opA, opB} = {16'h0000, 16'h8000};
            if (i % 8 == 5) opB = opA;                           // Zero difference
          end
          1: begin
            op = (i % 4 == 0) ? XOR : (i % 4 == 1) ? SLL : (i % 4 == 2) ? SRA : ROR;
            opB[3:0] = 4'((i / 4) % 16);            // Sweep every shift amount
          end
          2: begin
            op = (i % 2 == 0) ? PADDSB : RED;
            if (i % 10 == 0) {opA, opB} = {16'h7788, 16'h1188};  // Both lane limits
            if (i % 10 == 1) {opA, opB} = {16'h8080, 16'h8080};  // Smallest byte sum
            if (i % 10 == 3) {opA, opB} = {16'h7F7F, 16'h7F7F};  // Largest byte sum
          end
          3: begin
            op = (i % 2 == 0) ? LW : SW;
            if (i % 20 == 0) {opA, opB} = 32'hFFFF_FFFF;         // Address wrap
          end
          4: op = 4'(10 + i % 6);
          default: begin
            rnd = randWord();
            op  = rnd[3:0];                          // Any opcode, legal or not
            if (rnd[7:4] == 4'h0) opB = opA;
          end
        endcase
        issueOp(op, opA, opB);
      end
      @(negedge clk);
      issue = 1'b0;
      while (pendQ.size() != 0 || flagPending) @(posedge clk);
      $display("Test %0d %s: %0d operations, %0d errors",
               t + 1, names[t], OPS, errorCount - errMark);
    end
    $display("Summary: 6 tests, %0d checks, %0d errors, %0d assertion failures",
             checkCount, errorCount, dut0.checker0.assertFails);
    if (errorCount == 0 && dut0.checker0.assertFails == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- testbench/alu_checker.sv
module aluChecker import alu_pkg::*; (
  input logic     clk,
  input logic     rstN,
  input logic     issue,
  input logic     done,
  input aluRespS  resp,
  input aluFlagsS flags
);

  logic flagsFrozen;  // Last finished op belongs to the no-update class
  int   assertFails = 0;  // Failed assertions so far

  assign flagsFrozen = !(resp.op inside {ADD, SUB, XOR, SLL, SRA, ROR});

  ////////////////////////////////////////
  // Response timing
  ////////////////////////////////////////
  doneAfterIssue: assert property (@(posedge clk) disable iff (!rstN) issue |=> done)
    else begin
      assertFails++;
      $error("done missing one cycle after issue");
    end

  doneNeedsIssue: assert property (@(posedge clk) disable iff (!rstN) done |-> $past(issue))
    else begin
      assertFails++;
      $error("done without an issue one cycle earlier");
    end

  // Two done cycles in a row only for back-to-back strobes
  noStretchedDone: assert property (@(posedge clk) disable iff (!rstN)
    done && $past(done) |-> $past(issue) && $past(issue, 2))
    else begin
      assertFails++;
      $error("done held high without consecutive issues");
    end

  ////////////////////////////////////////
  // Flags and error result
  ////////////////////////////////////////
  flagsHeld: assert property (@(posedge clk) disable iff (!rstN)
    done && flagsFrozen |=> $stable(flags))
    else begin
      assertFails++;
      $error("flags changed after a no-update opcode");
    end

  errorZero: assert property (@(posedge clk) disable iff (!rstN)
    resp.error |-> resp.result == '0)
    else begin
      assertFails++;
      $error("error response with a nonzero result");
    end

endmodule

//--- design/aluTop.sv
`default_nettype none

module aluTop import alu_pkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     issue,
  input  aluReqS   req,
  output logic     done,
  output aluRespS  resp,
  output aluFlagsS flags
);

  ////////////////////////////////////////
  // Datapath and response register
  ////////////////////////////////////////
  aluUnit unit0 (
    .clk   (clk),
    .rstN  (rstN),
    .issue (issue),
    .req   (req),
    .done  (done),     // Also feeds the flag stage
    .resp  (resp)
  );

  ////////////////////////////////////////
  // Z/V/N state, one edge after done
  ////////////////////////////////////////
  flagRegister flags0 (
    .clk   (clk),
    .rstN  (rstN),
    .done  (done),
    .resp  (resp),
    .flags (flags)
  );

endmodule

`default_nettype wire

//--- design/flagRegister.sv
`default_nettype none

module flagRegister import alu_pkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     done,
  input  aluRespS  resp,
  output aluFlagsS flags
);

  logic resultZero;

  assign resultZero = (resp.result == '0);

  ////////////////////////////////////////
  // Flag update by opcode class
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (done) begin
      case (resp.op)
        // Arithmetic updates all three
        ADD, SUB: begin
          flags.z <= resultZero;
          flags.v <= resp.ovfl;
          flags.n <= resp.neg;
        end
        // Logic and shifts touch Z only
        XOR, SLL, SRA, ROR: begin
          flags.z <= resultZero;
        end
        default: begin
          // RED, PADDSB, LW, SW and illegal ops keep the flags
          flags <= flags;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/aluUnit.sv
`default_nettype none
`include "alu_params.svh"

module aluUnit import alu_pkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    issue,
  input  aluReqS  req,
  output logic    done,
  output aluRespS resp
);

  localparam int   MSB     = `DATA_WIDTH - 1;
  localparam dataT SAT_MAX = {1'b0, {MSB{1'b1}}};  // 16'h7FFF
  localparam dataT SAT_MIN = {1'b1, {MSB{1'b0}}};  // 16'h8000

  logic    isMem, isAddSub;
  dataT    opA, opB;               // Prepared operands
  dataT    addSum, satSum;
  logic    posOvfl, negOvfl;
  dataT    paddsbSum, redSum, shiftOut;
  aluRespS nextResp;

  ////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////
  assign isMem    = (req.op == LW) || (req.op == SW);
  assign isAddSub = (req.op == ADD) || (req.op == SUB);

  // Word-aligned base plus word offset for loads and stores
  assign opA = isMem ? {req.a[MSB:1], 1'b0} : req.a;
  assign opB = isMem ? {req.b[MSB-1:0], 1'b0} : req.b;

  // Functional units, all combinational
  claAdder adder0 (
    .a       (opA),
    .b       (opB),
    .sub     (req.op == SUB),
    .sum     (addSum),
    .posOvfl (posOvfl),
    .negOvfl (negOvfl)
  );

  paddsbUnit paddsb0 (.a(opA), .b(opB), .sum(paddsbSum));

  reductionUnit red0 (.a(opA), .b(opB), .sum(redSum));

  barrelShifter shift0 (
    .shiftIn  (opA),
    .mode     (req.op[1:0]),                 // Opcode low bits pick the shift kind
    .shamt    (opB[`SHAMT_WIDTH-1:0]),
    .shiftOut (shiftOut)
  );

  // Clamp ADD/SUB; address sums use addSum directly and wrap
  assign satSum = posOvfl ? SAT_MAX :
                  negOvfl ? SAT_MIN : addSum;

  ////////////////////////////////////////
  // Result select and illegal opcodes
  ////////////////////////////////////////
  always_comb begin
    nextResp      = '0;
    nextResp.op   = req.op;
    nextResp.ovfl = isAddSub & (posOvfl | negOvfl);
    nextResp.neg  = isAddSub & addSum[MSB];   // Raw sum sign, before clamping
    case (req.op)
      ADD, SUB:      nextResp.result = satSum;
      LW, SW:        nextResp.result = addSum;
      XOR:           nextResp.result = opA ^ opB;
      RED:           nextResp.result = redSum;
      SLL, SRA, ROR: nextResp.result = shiftOut;
      PADDSB:        nextResp.result = paddsbSum;
      default:       nextResp.error  = 1'b1;   // Result stays zero
    endcase
  end

  // One-cycle response stage
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      done <= 1'b0;
      resp <= '0;
    end else begin
      done <= issue;                  // Pulse follows every strobe
      if (issue) resp <= nextResp;    // Held until the next issue
    end
  end

endmodule

`default_nettype wire

//--- design/barrelShifter.sv
`default_nettype none
`include "alu_params.svh"

module barrelShifter import alu_pkg::*; (
  input  dataT       shiftIn,
  input  logic [1:0] mode,      // 00 SLL, 01 SRA, 10 ROR
  input  shamtT      shamt,
  output dataT       shiftOut
);

  localparam int W      = `DATA_WIDTH;
  localparam int STAGES = `SHAMT_WIDTH;

  logic [STAGES:0][W-1:0] stage;  // stage[k] is the value entering step k

  assign stage[0] = shiftIn;

  ////////////////////////////////////////
  // Steps of 1, 2, 4 and 8 bits
  ////////////////////////////////////////
  for (genvar k = 0; k < STAGES; k++) begin : gStage
    localparam int AMT = 1 << k;
    logic [W-1:0] shifted;

    always_comb begin
      case (mode)
        2'b01:   shifted = $signed(stage[k]) >>> AMT;                        // Keeps sign
        2'b10:   shifted = {stage[k][AMT-1:0], stage[k][W-1:AMT]};          // Wrap low bits
        default: shifted = stage[k] << AMT;                                  // Zero fill
      endcase
    end

    // Bit k of the amount enables this step
    assign stage[k+1] = shamt[k] ? shifted : stage[k];
  end

  assign shiftOut = stage[STAGES];

endmodule

`default_nettype wire

//--- design/reductionUnit.sv
`default_nettype none
`include "alu_params.svh"

module reductionUnit import alu_pkg::*; (
  input  dataT a,
  input  dataT b,
  output dataT sum
);

  logic [8:0] pairA;   // aHi + aLo, range -256..254
  logic [8:0] pairB;   // bHi + bLo
  logic [9:0] total;   // Full tree, range -512..508

  ////////////////////////////////////////
  // Level one: bytes of each operand
  ////////////////////////////////////////
  assign pairA = {a[15], a[15:8]} + {a[7], a[7:0]};  // Sign-extend each byte first
  assign pairB = {b[15], b[15:8]} + {b[7], b[7:0]};

  // Level two
  assign total = {pairA[8], pairA} + {pairB[8], pairB};

  // Widen to the datapath
  assign sum = {{(`DATA_WIDTH-10){total[9]}}, total};

endmodule

`default_nettype wire

//--- design/paddsbUnit.sv
`default_nettype none
`include "alu_params.svh"

module paddsbUnit import alu_pkg::*; (
  input  dataT a,
  input  dataT b,
  output dataT sum
);

  localparam int W     = `NIBBLE_WIDTH;
  localparam int LANES = `DATA_WIDTH / `NIBBLE_WIDTH;

  // Lane saturation limits
  localparam logic [W-1:0] LANE_MAX = {1'b0, {(W-1){1'b1}}};  // 0111
  localparam logic [W-1:0] LANE_MIN = {1'b1, {(W-1){1'b0}}};  // 1000

  ////////////////////////////////////////
  // Independent signed nibble adders
  ////////////////////////////////////////
  for (genvar lane = 0; lane < LANES; lane++) begin : gLane
    logic [W-1:0] x, y, raw;
    logic posSat, negSat;

    assign x   = a[lane*W +: W];
    assign y   = b[lane*W +: W];
    assign raw = x + y;             // Carry out of the lane is dropped

    // Overflow only when both inputs share a sign
    assign posSat = ~x[W-1] & ~y[W-1] &  raw[W-1];
    assign negSat =  x[W-1] &  y[W-1] & ~raw[W-1];

    assign sum[lane*W +: W] = posSat ? LANE_MAX :
                              negSat ? LANE_MIN : raw;
  end

endmodule

`default_nettype wire

//--- design/claAdder.sv
`default_nettype none
`include "alu_params.svh"

module claAdder import alu_pkg::*; (
  input  dataT a,
  input  dataT b,
  input  logic sub,
  output dataT sum,
  output logic posOvfl,
  output logic negOvfl
);

  localparam int GROUPS = `DATA_WIDTH / 4;  // Four 4-bit lookahead groups
  localparam int MSB    = `DATA_WIDTH - 1;

  dataT bIn;                        // B after optional inversion
  dataT gen, prop;                  // Bit generate / propagate
  dataT carry;                      // Carry into each bit
  logic [GROUPS-1:0] grpGen, grpProp;
  logic [GROUPS-1:0] grpCarry;      // Carry into each group

  assign bIn  = sub ? ~b : b;       // Subtract = add inverted B plus one
  assign gen  = a & bIn;
  assign prop = a ^ bIn;

  ////////////////////////////////////////
  // First level: carries inside a group
  ////////////////////////////////////////
  for (genvar grp = 0; grp < GROUPS; grp++) begin : gGroup
    localparam int LSB = 4 * grp;
    logic [3:0] g, p;
    logic cIn;

    assign g   = gen[LSB +: 4];
    assign p   = prop[LSB +: 4];
    assign cIn = grpCarry[grp];

    assign carry[LSB]   = cIn;
    assign carry[LSB+1] = g[0] | (p[0] & cIn);
    assign carry[LSB+2] = g[1] | (p[1] & g[0]) | (&p[1:0] & cIn);
    assign carry[LSB+3] = g[2] | (p[2] & g[1]) | (&p[2:1] & g[0]) | (&p[2:0] & cIn);

    // Group terms for the second level
    assign grpGen[grp]  = g[3] | (p[3] & g[2]) | (&p[3:2] & g[1]) | (&p[3:1] & g[0]);
    assign grpProp[grp] = &p;
  end

  ////////////////////////////////////////
  // Second level: carries between groups
  ////////////////////////////////////////
  assign grpCarry[0] = sub;         // Carry-in of one for subtraction
  assign grpCarry[1] = grpGen[0] | (grpProp[0] & sub);
  assign grpCarry[2] = grpGen[1] | (grpProp[1] & grpGen[0]) | (&grpProp[1:0] & sub);
  assign grpCarry[3] = grpGen[2] | (grpProp[2] & grpGen[1])
                     | (&grpProp[2:1] & grpGen[0]) | (&grpProp[2:0] & sub);

  assign sum = prop ^ carry;

  // Same operand signs but the sum sign flipped
  assign posOvfl = ~a[MSB] & ~bIn[MSB] &  sum[MSB];
  assign negOvfl =  a[MSB] &  bIn[MSB] & ~sum[MSB];

endmodule

`default_nettype wire

//--- design/alu_pkg.sv
`include "alu_params.svh"

package alu_pkg;

  // Common datapath words
  typedef logic [`DATA_WIDTH-1:0]  dataT;
  typedef logic [`SHAMT_WIDTH-1:0] shamtT;

  // Opcodes 1010..1111 are left unnamed and treated as illegal
  typedef enum logic [3:0] {
    ADD    = 4'b0000,
    SUB    = 4'b0001,
    XOR    = 4'b0010,
    RED    = 4'b0011,
    SLL    = 4'b0100,  // Low two bits double as shifter mode
    SRA    = 4'b0101,
    ROR    = 4'b0110,
    PADDSB = 4'b0111,
    LW     = 4'b1000,  // Address = (a & ~1) + (b << 1)
    SW     = 4'b1001
  } aluOpE;

  typedef struct packed {
    aluOpE op;
    dataT  a;
    dataT  b;
  } aluReqS;

  typedef struct packed {
    aluOpE op;      // Echo of the request opcode
    dataT  result;
    logic  error;   // Illegal opcode
    logic  ovfl;    // ADD/SUB saturated
    logic  neg;     // Sign of the raw ADD/SUB sum
  } aluRespS;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } aluFlagsS;

endpackage

//--- design/alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////

// Operand and result width
`define DATA_WIDTH 16

// One PADDSB lane
`define NIBBLE_WIDTH 4

// Shift amount taken from the low bits of operand B
`define SHAMT_WIDTH 4

`endif
